// File: Makefile
# Verilator simulation of the TCB memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_tcb_sys
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/tcb_if.sv
// TCB point to point link
// valid/ready request handshake with a fixed delay,
// non-handshaken response

`default_nettype none

interface tcb_if (
  input logic clk,
  input logic rst_n
);

  // handshake
  logic vld;
  logic rdy;

  // payloads
  tcb_pkg::tcb_req_t req;
  tcb_pkg::tcb_rsp_t rsp;

  ////////////////////////////////////////////////////////////
  // views
  ////////////////////////////////////////////////////////////

  // manager drives the request side
  modport man (
    input  clk,
    input  rst_n,
    output vld,
    output req,
    input  rdy,
    input  rsp
  );

  // subordinate answers with ready and response
  modport sub (
    input  clk,
    input  rst_n,
    input  vld,
    input  req,
    output rdy,
    output rsp
  );

endinterface : tcb_if

`default_nettype wire

// File: common/tcb_pkg.sv
// TCB memory subsystem definitions
// bus widths, response delay, bank map and the
// request/response structs shared by all blocks

`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////

  // word address width
  localparam int unsigned tcb_aw = 10;
  // data width
  localparam int unsigned tcb_dw = 32;
  // byte enable width, one per byte lane
  localparam int unsigned tcb_bw = tcb_dw / 8;

  // response delay after the transfer edge, in cycles
  localparam int unsigned tcb_dly = 1;
  // counter widths
  localparam int unsigned tcb_dly_w = $clog2(tcb_dly + 1);
  localparam int unsigned tcb_wait_w = 8;
  // last value of the response delay counter
  localparam logic [tcb_dly_w-1:0] tcb_dly_last = tcb_dly_w'(tcb_dly - 1);

  ////////////////////////////////////////////////////////////
  // bank map
  ////////////////////////////////////////////////////////////

  // number of memory banks
  localparam int unsigned tcb_banks = 4;
  // word address bits inside one bank (64 words)
  localparam int unsigned tcb_bank_aw = 6;

  // bank index, tcb_banks itself marks a miss
  typedef logic [2:0] tcb_sel_t;

  // selection for addresses above the mapped range
  localparam tcb_sel_t tcb_sel_miss = tcb_sel_t'(tcb_banks);

  ////////////////////////////////////////////////////////////
  // request and response payloads
  ////////////////////////////////////////////////////////////

  // request, held stable while vld is high
  typedef struct packed {
    logic              wen;  // write enable
    logic [tcb_aw-1:0] adr;  // word address
    logic [tcb_bw-1:0] ben;  // byte enables
    logic [tcb_dw-1:0] wdt;  // write data
  } tcb_req_t;

  // response, valid tcb_dly cycles after the transfer
  typedef struct packed {
    logic [tcb_dw-1:0] rdt;  // read data
    logic              err;  // error, unmapped address
  } tcb_rsp_t;

endpackage : tcb_pkg

`default_nettype wire

// File: files.f
common/tcb_pkg.sv
common/tcb_if.sv
hw/wb2tcb/wb2tcb_man.sv
hw/tcb_dec.sv
hw/tcb_mem/tcb_mem.sv
hw/tcb_rsp_mux.sv
hw/tcb_sys_top.sv
verification/tb_clk.sv
verification/tb_tcb_sys.sv

// File: hw/tcb_dec.sv
// TCB address decoder
// steers a request to one of the memory banks by its upper
// address bits, unmapped addresses are accepted at once
// and flagged as a miss for the response multiplexer

`default_nettype none

module tcb_dec (
  // from the bridge
  tcb_if.sub                 man_bus,
  // to the banks
  tcb_if.man                 bank_bus [tcb_pkg::tcb_banks],
  // to the response multiplexer
  output logic               trn,
  output tcb_pkg::tcb_sel_t  sel
);

  ////////////////////////////////////////////////////////////
  // bank selection
  ////////////////////////////////////////////////////////////

  // address bits above one bank
  logic [tcb_pkg::tcb_aw-1:tcb_pkg::tcb_bank_aw] bank_adr;

  logic                           miss;
  logic [tcb_pkg::tcb_banks-1:0]  bank_hit;
  logic [tcb_pkg::tcb_banks-1:0]  bank_rdy;

  assign bank_adr = man_bus.req.adr[tcb_pkg::tcb_aw-1:tcb_pkg::tcb_bank_aw];

  // everything above the last bank is unmapped
  assign miss = (bank_adr >= tcb_pkg::tcb_banks);

  assign sel = miss ? tcb_pkg::tcb_sel_miss : tcb_pkg::tcb_sel_t'(bank_adr);

  ////////////////////////////////////////////////////////////
  // request fan-out
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < tcb_pkg::tcb_banks; b++) begin : g_bank
    // one-hot bank match
    assign bank_hit[b] = (sel == tcb_pkg::tcb_sel_t'(b));

    // only the selected bank sees vld
    assign bank_bus[b].vld = man_bus.vld & bank_hit[b];
    // payload goes to all banks
    assign bank_bus[b].req = man_bus.req;

    // collect ready
    assign bank_rdy[b] = bank_bus[b].rdy;
  end

  ////////////////////////////////////////////////////////////
  // ready return
  ////////////////////////////////////////////////////////////

  // a miss never stalls
  assign man_bus.rdy = miss | (|(bank_hit & bank_rdy));

  // transfer strobe for the multiplexer
  assign trn = man_bus.vld & man_bus.rdy;

endmodule : tcb_dec

`default_nettype wire

// File: hw/tcb_mem/tcb_mem.sv
// TCB memory bank
// 64 words with byte enabled writes, read data after a fixed
// delay, ready drops for one cycle after every write

`default_nettype none

module tcb_mem (
  tcb_if.sub bus
);

  // storage
  logic [tcb_pkg::tcb_dw-1:0] mem [2 ** tcb_pkg::tcb_bank_aw];

  // read data delay line
  logic [tcb_pkg::tcb_dw-1:0] rdt_dly [tcb_pkg::tcb_dly];

  logic                            trn;
  logic [tcb_pkg::tcb_bank_aw-1:0] adr;
  // write recovery
  logic                            wr_stall;

  assign trn = bus.vld & bus.rdy;
  // word inside this bank
  assign adr = bus.req.adr[tcb_pkg::tcb_bank_aw-1:0];

  ////////////////////////////////////////////////////////////
  // write and read
  ////////////////////////////////////////////////////////////

  // byte lanes written on the transfer edge
  always_ff @(posedge bus.clk) begin
    if (trn && bus.req.wen) begin
      for (int i = 0; i < tcb_pkg::tcb_bw; i++) begin
        if (bus.req.ben[i]) begin
          mem[adr][8*i +: 8] <= bus.req.wdt[8*i +: 8];
        end
      end
    end
  end

  // first stage loads on a read while the rest shift
  always_ff @(posedge bus.clk) begin
    if (trn && !bus.req.wen) begin
      rdt_dly[0] <= mem[adr];
    end
    for (int i = 1; i < tcb_pkg::tcb_dly; i++) begin
      rdt_dly[i] <= rdt_dly[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // handshake and response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus.clk or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      wr_stall <= 1'b0;
    end else begin
      wr_stall <= trn & bus.req.wen;
    end
  end

  assign bus.rdy = ~wr_stall;

  // a bank itself never errors
  assign bus.rsp = '{rdt: rdt_dly[tcb_pkg::tcb_dly-1], err: 1'b0};

endmodule : tcb_mem

`default_nettype wire

// File: hw/tcb_rsp_mux.sv
// TCB response multiplexer
// remembers which bank took the transfer and returns its
// response after the delay, or an error for a miss

`default_nettype none

module tcb_rsp_mux (
  input  logic               clk,
  input  logic               rst_n,
  // from the decoder
  input  logic               trn,
  input  tcb_pkg::tcb_sel_t  sel,
  // bank responses
  input  tcb_pkg::tcb_rsp_t  bank_rsp [tcb_pkg::tcb_banks],
  // to the bridge
  output tcb_pkg::tcb_rsp_t  rsp
);

  // selection delay line, aligned with the bank read delay
  tcb_pkg::tcb_sel_t sel_dly [tcb_pkg::tcb_dly];

  ////////////////////////////////////////////////////////////
  // selection pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < tcb_pkg::tcb_dly; i++) begin
        sel_dly[i] <= tcb_pkg::tcb_sel_miss;
      end
    end else begin
      // capture on the transfer edge
      if (trn) begin
        sel_dly[0] <= sel;
      end
      for (int i = 1; i < tcb_pkg::tcb_dly; i++) begin
        sel_dly[i] <= sel_dly[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response select
  ////////////////////////////////////////////////////////////

  always_comb begin
    // miss, error with zero data
    rsp = '{rdt: '0, err: 1'b1};
    for (int b = 0; b < tcb_pkg::tcb_banks; b++) begin
      if (sel_dly[tcb_pkg::tcb_dly-1] == tcb_pkg::tcb_sel_t'(b)) begin
        rsp = bank_rsp[b];
      end
    end
  end

endmodule : tcb_rsp_mux

`default_nettype wire

// File: hw/tcb_sys_top.sv
// TCB memory subsystem top level
// Wishbone classic host port, bridge, address decoder,
// four memory banks and the response multiplexer

`default_nettype none

module tcb_sys_top (
  input  logic                        bus,
  input  logic                        rst_n,
  // wishbone classic
  input  logic                        cyc,
  input  logic                        stb,
  input  logic                        we,
  input  logic [tcb_pkg::tcb_aw-1:0]  adr,
  input  logic [tcb_pkg::tcb_bw-1:0]  sel,
  input  logic [tcb_pkg::tcb_dw-1:0]  dat_w,
  output logic [tcb_pkg::tcb_dw-1:0]  dat_r,
  output logic                        ack,
  output logic                        err
);

  // bridge to decoder
  tcb_if tcb_man_bus (.clk(bus), .rst_n(rst_n));
  // decoder to banks
  tcb_if tcb_bank_bus [tcb_pkg::tcb_banks] (.clk(bus), .rst_n(rst_n));

  // decoder to multiplexer
  logic               dec_trn;
  tcb_pkg::tcb_sel_t  dec_sel;

  // response path
  tcb_pkg::tcb_rsp_t  bank_rsp [tcb_pkg::tcb_banks];
  tcb_pkg::tcb_rsp_t  mux_rsp;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  wb2tcb_man man0 (
    .clk   (bus),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .err   (err),
    .bus   (tcb_man_bus),
    .rsp   (mux_rsp)
  );

  tcb_dec dec0 (
    .man_bus  (tcb_man_bus),
    .bank_bus (tcb_bank_bus),
    .trn      (dec_trn),
    .sel      (dec_sel)
  );

  // memory banks
  for (genvar b = 0; b < tcb_pkg::tcb_banks; b++) begin : g_mem
    tcb_mem mem0 (
      .bus (tcb_bank_bus[b])
    );
    assign bank_rsp[b] = tcb_bank_bus[b].rsp;
  end

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  tcb_rsp_mux mux0 (
    .clk      (bus),
    .rst_n    (rst_n),
    .trn      (dec_trn),
    .sel      (dec_sel),
    .bank_rsp (bank_rsp),
    .rsp      (mux_rsp)
  );

endmodule : tcb_sys_top

`default_nettype wire

// File: hw/wb2tcb/wb2tcb_man.sv
// Wishbone classic to TCB bridge
// takes one Wishbone classic cycle at a time, issues it as a TCB request
// and answers with ack or err once the TCB response arrives

`default_nettype none

module wb2tcb_man (
  input  logic                         clk,
  input  logic                         rst_n,
  // wishbone classic subordinate side
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [tcb_pkg::tcb_aw-1:0]   adr,
  input  logic [tcb_pkg::tcb_bw-1:0]   sel,
  input  logic [tcb_pkg::tcb_dw-1:0]   dat_w,
  output logic [tcb_pkg::tcb_dw-1:0]   dat_r,
  output logic                         ack,
  output logic                         err,
  // tcb manager side
  tcb_if.man                           bus,
  // response back from the multiplexer
  input  tcb_pkg::tcb_rsp_t            rsp
);

  ////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_rsp
  } state_t;

  state_t state;

  // latched request
  tcb_pkg::tcb_req_t req_q;

  // cycles since the transfer edge
  logic [tcb_pkg::tcb_dly_w-1:0] dly_cnt;

  logic start;
  logic trn;
  logic rsp_due;

  // host still holds stb during the ack cycle so ignore it there
  assign start   = cyc & stb & ~ack & ~err;
  assign trn     = bus.vld & bus.rdy;
  assign rsp_due = (dly_cnt == tcb_pkg::tcb_dly_last);

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      dly_cnt  <= '0;
      ack      <= 1'b0;
      err      <= 1'b0;
    end else begin
      // single cycle strobes
      ack <= 1'b0;
      err <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_req;
          end
        end
        st_req: begin
          if (trn) begin
            state   <= st_rsp;
            dly_cnt <= '0;
          end
        end
        st_rsp: begin
          if (rsp_due) begin
            ack   <= ~rsp.err;
            err   <= rsp.err;
            state <= st_idle;
          end else begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // request and read data payloads
  always_ff @(posedge clk) begin
    if ((state == st_idle) && start) begin
      req_q <= '{wen: we, adr: adr, ben: sel, wdt: dat_w};
    end
    if ((state == st_rsp) && rsp_due) begin
      dat_r <= rsp.rdt;
    end
  end

  // vld held until the transfer
  assign bus.vld = (state == st_req);
  assign bus.req = req_q;

endmodule : wb2tcb_man

`default_nettype wire

// File: verification/tb_clk.sv
// testbench clock and reset
// 40 ns clock, active low reset held for the first 16 cycles

`default_nettype none

module tb_clk (
  output logic bus,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam time half_period = 20ns;
  localparam int unsigned reset_cycles = 16;

  initial begin
    bus   = 1'b0;
    rst_n = 1'b0;
    fork
      forever #(half_period) bus = ~bus;
      begin
        repeat (reset_cycles) @(posedge bus);
        // release on a rising edge
        rst_n <= 1'b1;
      end
    join
  end

endmodule : tb_clk

`default_nettype wire

// File: verification/tb_tcb_sys.sv
// testbench for the TCB memory subsystem
// random Wishbone classic cycles from a fixed seed, checked
// against a byte-lane model of the mapped words

`default_nettype none

module tb_tcb_sys;

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [tcb_pkg::tcb_aw-1:0] adr_t;
  typedef logic [tcb_pkg::tcb_bw-1:0] ben_t;
  typedef logic [tcb_pkg::tcb_dw-1:0] dat_t;

  localparam int unsigned seed = 3;
  localparam int unsigned mapped = tcb_pkg::tcb_banks << tcb_pkg::tcb_bank_aw;
  localparam int unsigned adr_space = 2 ** tcb_pkg::tcb_aw;
  // wait limits in cycles
  localparam int unsigned ack_timeout = 50;
  localparam int unsigned reset_timeout = 100;

  logic bus;
  logic rst_n;
  logic cyc;
  logic stb;
  logic we;
  adr_t adr;
  ben_t sel;
  dat_t dat_w;
  dat_t dat_r;
  logic ack;
  logic err;

  // reference contents of the mapped words
  dat_t model [mapped];

  int unsigned errors = 0;
  int unsigned checks = 0;
  // set on a timeout to skip the remaining cycles
  logic hung = 1'b0;

  tb_clk clk0 (.bus(bus), .rst_n(rst_n));

  tcb_sys_top dut0 (
    .bus   (bus),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .err   (err)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string sig, input adr_t a, input dat_t got,
                                 input dat_t exp);
    errors++;
    $display("FAIL %s at adr %h: got %h expected %h", sig, a, got, exp);
  endtask

  // ack and err must both be low
  task automatic check_strobes_low(input string phase);
    if (ack !== 1'b0) begin
      errors++;
      $display("FAIL ack %s: got %h expected %h", phase, ack, 1'b0);
    end
    if (err !== 1'b0) begin
      errors++;
      $display("FAIL err %s: got %h expected %h", phase, err, 1'b0);
    end
  endtask

  // one Wishbone cycle that leaves cyc high
  task automatic wb_cycle(input logic w, input adr_t a, input ben_t s, input dat_t d);
    int unsigned cnt;
    int unsigned idx;
    if (hung) return;
    @(posedge bus);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= w;
    adr   <= a;
    sel   <= s;
    dat_w <= d;
    cnt = 0;
    @(negedge bus);
    while (!(ack || err) && cnt < ack_timeout) begin
      cnt++;
      @(negedge bus);
    end
    if (!(ack || err)) begin
      errors++;
      $display("timeout: access to adr %h got neither ack nor err", a);
      hung = 1'b1;
      return;
    end
    checks++;
    if (a >= mapped) begin
      // unmapped gives err with zero data
      if (err !== 1'b1) report_mismatch("err", a, dat_t'(err), 1);
      if (ack !== 1'b0) report_mismatch("ack", a, dat_t'(ack), 0);
      if (dat_r !== '0) report_mismatch("dat_r", a, dat_r, 0);
    end else begin
      idx = int'(a);
      if (ack !== 1'b1) report_mismatch("ack", a, dat_t'(ack), 1);
      if (err !== 1'b0) report_mismatch("err", a, dat_t'(err), 0);
      if (w) begin
        for (int i = 0; i < tcb_pkg::tcb_bw; i++) begin
          if (s[i]) model[idx][8*i +: 8] = d[8*i +: 8];
        end
      end else if (dat_r !== model[idx]) begin
        report_mismatch("dat_r", a, dat_r, model[idx]);
      end
    end
  endtask

  // host drops cyc and stb
  task automatic end_cycle();
    if (hung) return;
    @(posedge bus);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  function automatic adr_t rand_mapped();
    return adr_t'($urandom % mapped);
  endfunction

  function automatic adr_t rand_unmapped();
    return adr_t'(mapped + ($urandom % (adr_space - mapped)));
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned cnt;
    adr_t a;
    adr_t b;
    void'($urandom(seed));
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    sel   = '0;
    dat_w = '0;

    // no strobes while in reset
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < reset_timeout) begin
      @(negedge bus);
      check_strobes_low("during reset");
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("timeout: reset was never released");
      hung = 1'b1;
    end
    // and just after it
    repeat (4) begin
      @(negedge bus);
      check_strobes_low("after reset");
    end

    // fill every word and read each one back at once
    for (int i = 0; i < mapped; i++) begin
      wb_cycle(1'b1, adr_t'(i), '1, dat_t'($urandom));
      wb_cycle(1'b0, adr_t'(i), '0, '0);
      end_cycle();
    end

    // partial writes by byte enables
    repeat (64) begin
      a = rand_mapped();
      wb_cycle(1'b1, a, ben_t'($urandom), dat_t'($urandom));
      end_cycle();
      wb_cycle(1'b0, a, '0, '0);
      end_cycle();
    end

    // unmapped space leaves its alias in mapped space intact
    repeat (16) begin
      a = rand_unmapped();
      wb_cycle(1'b1, a, '1, dat_t'($urandom));
      wb_cycle(1'b0, a, '0, '0);
      wb_cycle(1'b0, adr_t'(a % mapped), '0, '0);
      end_cycle();
    end

    // write then another access to the same bank without an idle gap
    repeat (32) begin
      a = rand_mapped();
      b = {a[tcb_pkg::tcb_aw-1:tcb_pkg::tcb_bank_aw],
           tcb_pkg::tcb_bank_aw'($urandom)};
      wb_cycle(1'b1, a, ben_t'($urandom), dat_t'($urandom));
      wb_cycle(1'(($urandom % 2)), b, ben_t'($urandom), dat_t'($urandom));
      wb_cycle(1'b0, a, '0, '0);
      end_cycle();
    end

    // mixed traffic that is mostly mapped
    repeat (400) begin
      a = (($urandom % 10) < 8) ? rand_mapped() : rand_unmapped();
      wb_cycle(1'(($urandom % 2)), a, ben_t'($urandom), dat_t'($urandom));
      if ($urandom % 2) end_cycle();
    end
    end_cycle();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_tcb_sys

`default_nettype wire
